// File: logic/id_queue_pkg.sv
/*
 * Shared constants and types of the ID queue, which keeps FIFO order among
 * entries with the same ID and stores them as linked lists in one data pool
 */
package id_queue_pkg;

    // Bits of an ID carried by every entry
    localparam int ID_WIDTH = 3;

    // Total number of data entries, shared by all IDs
    localparam int CAPACITY = 6;

    // Bits of the data word stored with each entry
    localparam int DATA_WIDTH = 16;

    // Number of distinct IDs that the ID width can name
    localparam int N_IDS = 2 ** ID_WIDTH;

    // One head-tail slot per live ID is enough, and there can never be more
    // live IDs than stored entries
    localparam int HT_CAPACITY = (N_IDS < CAPACITY) ? N_IDS : CAPACITY;

    // Index widths of both tables, kept at one bit even for a single entry
    localparam int HT_IDX_WIDTH = (HT_CAPACITY > 1) ? $clog2(HT_CAPACITY) : 1;
    localparam int LD_IDX_WIDTH = (CAPACITY > 1) ? $clog2(CAPACITY) : 1;

    typedef logic [ID_WIDTH-1:0]     id_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [HT_IDX_WIDTH-1:0] ht_idx_t;
    typedef logic [LD_IDX_WIDTH-1:0] ld_idx_t;

    // Head-tail slot, which points at the first and last data entry of one ID
    typedef struct packed {
        id_t     id;
        ld_idx_t head;
        ld_idx_t tail;
        logic    free;
    } ht_entry_t;

    // Data entry of the linked store
    // The next pointer is only meaningful while the entry is not the tail
    typedef struct packed {
        data_t   data;
        ld_idx_t next;
        logic    free;
    } ld_entry_t;

    // Whole data pool, handed to the exists search as one vector
    typedef ld_entry_t [CAPACITY-1:0] ld_table_t;

    // Result of matching one ID against the head-tail table
    typedef struct packed {
        logic    hit;
        ht_idx_t idx;
        ld_idx_t head;
        ld_idx_t tail;
    } ht_lookup_t;

    // Table operation selected by the controller for the coming edge
    typedef enum logic [2:0] {
        OP_NONE,
        OP_PUSH_NEW,
        OP_PUSH_APPEND,
        OP_PEEK,
        OP_POP_ADVANCE,
        OP_POP_LAST
    } queue_op_e;

endpackage

// File: logic/id_queue_ctrl.sv
/*
 * ID queue controller
 * Gives the push port priority and picks one table operation per cycle
 */
`timescale 1ns/1ps

module id_queue_ctrl (
    input  logic                     inp_req_i,
    input  id_queue_pkg::id_t        inp_id_i,
    input  logic                     oup_req_i,
    input  id_queue_pkg::id_t        oup_id_i,
    input  logic                     oup_pop_i,
    input  logic                     full_i,
    input  id_queue_pkg::ht_lookup_t lookup_i,
    output logic                     inp_gnt_o,
    output logic                     oup_gnt_o,
    output logic                     oup_data_valid_o,
    output id_queue_pkg::id_t        lookup_id_o,
    output id_queue_pkg::queue_op_e  op_o
);

    // High when a push is taken at the next edge
    logic push_gnt;

    // The push grant depends on fullness alone, not on the request
    assign inp_gnt_o = !full_i;
    assign push_gnt  = inp_req_i && !full_i;

    // Only one table access per cycle, so a taken push blocks the output port
    assign oup_gnt_o = oup_req_i && !push_gnt;

    // The output data is valid only if the requested ID is stored
    assign oup_data_valid_o = oup_gnt_o && lookup_i.hit;

    // The single lookup path serves whichever port owns the cycle
    assign lookup_id_o = push_gnt ? inp_id_i : oup_id_i;

    always_comb begin
        op_o = id_queue_pkg::OP_NONE;
        if (push_gnt) begin
            // A new ID opens a fresh list, a known ID extends its list
            if (lookup_i.hit) begin
                op_o = id_queue_pkg::OP_PUSH_APPEND;
            end else begin
                op_o = id_queue_pkg::OP_PUSH_NEW;
            end
        end else if (oup_gnt_o && lookup_i.hit) begin
            if (!oup_pop_i) begin
                op_o = id_queue_pkg::OP_PEEK;
            end else if (lookup_i.head == lookup_i.tail) begin
                // Last entry of this ID, so its head-tail slot goes away too
                op_o = id_queue_pkg::OP_POP_LAST;
            end else begin
                op_o = id_queue_pkg::OP_POP_ADVANCE;
            end
        end
    end

endmodule

// File: logic/id_head_tail_table.sv
/*
 * Head-tail table of the ID queue
 * Maps each live ID to the head and tail of its list in the data store
 */
`timescale 1ns/1ps

module id_head_tail_table (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  id_queue_pkg::id_t        lookup_id_i,
    input  id_queue_pkg::queue_op_e  op_i,
    input  id_queue_pkg::ld_idx_t    alloc_idx_i,
    input  id_queue_pkg::ld_idx_t    head_next_i,
    output id_queue_pkg::ht_lookup_t lookup_o
);

    // Slot registers
    id_queue_pkg::ht_entry_t [id_queue_pkg::HT_CAPACITY-1:0] ht_q;

    // One bit per slot that holds the looked-up ID
    logic [id_queue_pkg::HT_CAPACITY-1:0] match;

    id_queue_pkg::ht_idx_t match_idx;
    id_queue_pkg::ht_idx_t free_idx;

    // Compare the ID against every occupied slot
    always_comb begin
        for (int i = 0; i < id_queue_pkg::HT_CAPACITY; i++) begin
            match[i] = !ht_q[i].free && (ht_q[i].id == lookup_id_i);
        end
    end

    // An ID lives in at most one slot, so the match vector is one-hot
    always_comb begin
        match_idx = '0;
        for (int i = 0; i < id_queue_pkg::HT_CAPACITY; i++) begin
            if (match[i]) begin
                match_idx = id_queue_pkg::ht_idx_t'(i);
            end
        end
    end

    // Lowest free slot, found by scanning downwards
    // A new ID always finds one while the data store has room
    always_comb begin
        free_idx = '0;
        for (int i = id_queue_pkg::HT_CAPACITY - 1; i >= 0; i--) begin
            if (ht_q[i].free) begin
                free_idx = id_queue_pkg::ht_idx_t'(i);
            end
        end
    end

    // Head and tail of the matched slot go to the controller and the store
    always_comb begin
        lookup_o.hit  = |match;
        lookup_o.idx  = match_idx;
        lookup_o.head = ht_q[match_idx].head;
        lookup_o.tail = ht_q[match_idx].tail;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < id_queue_pkg::HT_CAPACITY; i++) begin
                ht_q[i] <= '{free: 1'b1, default: '0};
            end
        end else begin
            case (op_i)
                id_queue_pkg::OP_PUSH_NEW: begin
                    // First entry of this ID is both head and tail
                    ht_q[free_idx] <= '{
                        id:   lookup_id_i,
                        head: alloc_idx_i,
                        tail: alloc_idx_i,
                        free: 1'b0
                    };
                end
                id_queue_pkg::OP_PUSH_APPEND: begin
                    ht_q[match_idx].tail <= alloc_idx_i;
                end
                id_queue_pkg::OP_POP_ADVANCE: begin
                    // The store supplies the old head's successor
                    ht_q[match_idx].head <= head_next_i;
                end
                id_queue_pkg::OP_POP_LAST: begin
                    ht_q[match_idx] <= '{free: 1'b1, default: '0};
                end
                default: begin
                    // Peek and idle cycles leave the table as it is
                end
            endcase
        end
    end

endmodule

// File: logic/id_linked_data_store.sv
/*
 * Linked data store of the ID queue
 * Holds the data pool as singly linked lists, one list per live ID
 */
`timescale 1ns/1ps

module id_linked_data_store (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  id_queue_pkg::queue_op_e  op_i,
    input  id_queue_pkg::data_t      inp_data_i,
    input  id_queue_pkg::ht_lookup_t lookup_i,
    output logic                     full_o,
    output id_queue_pkg::ld_idx_t    alloc_idx_o,
    output id_queue_pkg::data_t      head_data_o,
    output id_queue_pkg::ld_idx_t    head_next_o,
    output id_queue_pkg::ld_table_t  table_o
);

    // Entry registers
    id_queue_pkg::ld_table_t table_q;

    // Free flags gathered from all entries
    logic [id_queue_pkg::CAPACITY-1:0] free_vec;

    always_comb begin
        for (int i = 0; i < id_queue_pkg::CAPACITY; i++) begin
            free_vec[i] = table_q[i].free;
        end
    end

    // No free entry means no push can be taken
    assign full_o = !(|free_vec);

    // Lowest free entry is the target of the next push
    always_comb begin
        alloc_idx_o = '0;
        for (int i = id_queue_pkg::CAPACITY - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                alloc_idx_o = id_queue_pkg::ld_idx_t'(i);
            end
        end
    end

    // Head of the looked-up list, zero when the ID is not stored
    assign head_data_o = lookup_i.hit ? table_q[lookup_i.head].data : '0;

    // Successor of the head, used when a pop advances the list
    assign head_next_o = table_q[lookup_i.head].next;

    assign table_o = table_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < id_queue_pkg::CAPACITY; i++) begin
                table_q[i] <= '{free: 1'b1, default: '0};
            end
        end else begin
            case (op_i)
                id_queue_pkg::OP_PUSH_NEW: begin
                    table_q[alloc_idx_o] <= '{data: inp_data_i, next: '0, free: 1'b0};
                end
                id_queue_pkg::OP_PUSH_APPEND: begin
                    table_q[alloc_idx_o] <= '{data: inp_data_i, next: '0, free: 1'b0};
                    // The old tail is occupied, so it never aliases the new entry
                    table_q[lookup_i.tail].next <= alloc_idx_o;
                end
                id_queue_pkg::OP_POP_ADVANCE,
                id_queue_pkg::OP_POP_LAST: begin
                    // Data and link of a freed entry are left stale
                    table_q[lookup_i.head].free <= 1'b1;
                end
                default: begin
                    // Peek and idle cycles keep all entries
                end
            endcase
        end
    end

endmodule

// File: logic/id_exists_search.sv
/*
 * Masked exists search over every occupied entry of the data store
 */
`timescale 1ns/1ps

module id_exists_search (
    input  id_queue_pkg::ld_table_t table_i,
    input  id_queue_pkg::data_t     exists_data_i,
    input  id_queue_pkg::data_t     exists_mask_i,
    input  logic                    exists_req_i,
    output logic                    exists_o,
    output logic                    exists_gnt_o
);

    // One match flag per data entry
    logic [id_queue_pkg::CAPACITY-1:0] entry_hit;

    for (genvar i = 0; i < id_queue_pkg::CAPACITY; i++) begin : gen_cmp
        // Only bits set in the mask take part in the comparison
        // A zero mask therefore matches any occupied entry
        assign entry_hit[i] = !table_i[i].free &&
                (((table_i[i].data ^ exists_data_i) & exists_mask_i) == '0);
    end

    // The search needs no arbitration and answers in the same cycle
    assign exists_gnt_o = exists_req_i;
    assign exists_o     = exists_req_i && (|entry_hit);

endmodule

// File: logic/id_queue.sv
/*
 * ID queue top level
 * Connects the controller, the head-tail table, the data store and the search
 */
`timescale 1ns/1ps

module id_queue (
    input  logic                clk_i,
    input  logic                rst_ni,

    // Push port
    input  id_queue_pkg::id_t   inp_id_i,
    input  id_queue_pkg::data_t inp_data_i,
    input  logic                inp_req_i,
    output logic                inp_gnt_o,

    // Peek and pop by ID
    input  id_queue_pkg::id_t   oup_id_i,
    input  logic                oup_pop_i,
    input  logic                oup_req_i,
    output id_queue_pkg::data_t oup_data_o,
    output logic                oup_data_valid_o,
    output logic                oup_gnt_o,

    // Masked search, independent of the other two ports
    input  id_queue_pkg::data_t exists_data_i,
    input  id_queue_pkg::data_t exists_mask_i,
    input  logic                exists_req_i,
    output logic                exists_o,
    output logic                exists_gnt_o
);

    id_queue_pkg::id_t          lookup_id;
    id_queue_pkg::ht_lookup_t   lookup;
    id_queue_pkg::queue_op_e    op;
    logic                       full;
    id_queue_pkg::ld_idx_t      alloc_idx;
    id_queue_pkg::ld_idx_t      head_next;
    id_queue_pkg::ld_table_t    ld_table;

    id_queue_ctrl i_ctrl (
        .inp_req_i        (inp_req_i),
        .inp_id_i         (inp_id_i),
        .oup_req_i        (oup_req_i),
        .oup_id_i         (oup_id_i),
        .oup_pop_i        (oup_pop_i),
        .full_i           (full),
        .lookup_i         (lookup),
        .inp_gnt_o        (inp_gnt_o),
        .oup_gnt_o        (oup_gnt_o),
        .oup_data_valid_o (oup_data_valid_o),
        .lookup_id_o      (lookup_id),
        .op_o             (op)
    );

    id_head_tail_table i_ht_table (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lookup_id_i (lookup_id),
        .op_i        (op),
        .alloc_idx_i (alloc_idx),
        .head_next_i (head_next),
        .lookup_o    (lookup)
    );

    // Head data of the looked-up ID drives the output port directly
    id_linked_data_store i_ld_store (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .op_i        (op),
        .inp_data_i  (inp_data_i),
        .lookup_i    (lookup),
        .full_o      (full),
        .alloc_idx_o (alloc_idx),
        .head_data_o (oup_data_o),
        .head_next_o (head_next),
        .table_o     (ld_table)
    );

    id_exists_search i_exists (
        .table_i       (ld_table),
        .exists_data_i (exists_data_i),
        .exists_mask_i (exists_mask_i),
        .exists_req_i  (exists_req_i),
        .exists_o      (exists_o),
        .exists_gnt_o  (exists_gnt_o)
    );

endmodule

// File: verif/tb_id_queue.sv
/*
 * Directed testbench of the ID queue
 * Checks push, peek, pop, back-pressure and the exists search against a per-ID model
 */
`timescale 1ns/1ps

module tb_id_queue;

    localparam int CLK_PERIOD = 10;
    // All tests together need under two hundred cycles
    // The limit leaves a wide margin above that
    localparam int WATCHDOG_CYCLES = 2000;

    logic                clk_i;
    logic                rst_ni;
    id_queue_pkg::id_t   inp_id_i;
    id_queue_pkg::data_t inp_data_i;
    logic                inp_req_i;
    logic                inp_gnt_o;
    id_queue_pkg::id_t   oup_id_i;
    logic                oup_pop_i;
    logic                oup_req_i;
    id_queue_pkg::data_t oup_data_o;
    logic                oup_data_valid_o;
    logic                oup_gnt_o;
    id_queue_pkg::data_t exists_data_i;
    id_queue_pkg::data_t exists_mask_i;
    logic                exists_req_i;
    logic                exists_o;
    logic                exists_gnt_o;

    // Expected contents, one FIFO per ID in push order
    id_queue_pkg::data_t model_q [id_queue_pkg::N_IDS][$];
    int seed;

    // Every testbench signal carries the name of the port it drives or watches
    id_queue DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Inputs change 1 ns after the rising edge
    // Outputs are sampled 4 ns later
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    function automatic id_queue_pkg::data_t rand_data();
        return id_queue_pkg::data_t'($random(seed));
    endfunction

    function automatic int model_count();
        int n;
        n = 0;
        for (int i = 0; i < id_queue_pkg::N_IDS; i++) begin
            n += model_q[i].size();
        end
        return n;
    endfunction

    // A stored word matches when no bit set in the mask differs from the search word
    function automatic logic model_exists(input id_queue_pkg::data_t data,
                                          input id_queue_pkg::data_t mask);
        id_queue_pkg::data_t word;
        logic                differs;
        for (int i = 0; i < id_queue_pkg::N_IDS; i++) begin
            for (int j = 0; j < model_q[i].size(); j++) begin
                word    = model_q[i][j];
                differs = 1'b0;
                for (int b = 0; b < id_queue_pkg::DATA_WIDTH; b++) begin
                    if (mask[b] && (word[b] != data[b])) begin
                        differs = 1'b1;
                    end
                end
                if (!differs) begin
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    // Holds the request until the grant shows up
    // The watchdog bounds the wait
    task automatic push_entry(input id_queue_pkg::id_t id, input id_queue_pkg::data_t data);
        inp_id_i   = id;
        inp_data_i = data;
        inp_req_i  = 1'b1;
        #4;
        while (!inp_gnt_o) begin
            @(posedge clk_i);
            #5;
        end
        model_q[id].push_back(data);
        next_cycle();
        inp_req_i = 1'b0;
    endtask

    // Peek or pop one ID and compare against the head of its model FIFO
    task automatic access_entry(input id_queue_pkg::id_t id, input logic pop);
        id_queue_pkg::data_t exp_data;
        logic                exp_valid;
        exp_valid = model_q[id].size() > 0;
        exp_data  = exp_valid ? model_q[id][0] : '0;
        oup_id_i  = id;
        oup_pop_i = pop;
        oup_req_i = 1'b1;
        #4;
        check_value("oup_gnt_o", 32'(oup_gnt_o), 32'd1);
        check_value("oup_data_valid_o", 32'(oup_data_valid_o), 32'(exp_valid));
        check_value("oup_data_o", 32'(oup_data_o), 32'(exp_data));
        if (pop && exp_valid) begin
            void'(model_q[id].pop_front());
        end
        next_cycle();
        oup_req_i = 1'b0;
        oup_pop_i = 1'b0;
    endtask

    task automatic probe_exists(input id_queue_pkg::data_t data,
                                input id_queue_pkg::data_t mask, input logic req);
        exists_data_i = data;
        exists_mask_i = mask;
        exists_req_i  = req;
        #4;
        check_value("exists_gnt_o", 32'(exists_gnt_o), 32'(req));
        check_value("exists_o", 32'(exists_o), 32'(req && model_exists(data, mask)));
        next_cycle();
        exists_req_i = 1'b0;
    endtask

    task automatic check_push_grant(input logic expected);
        #4;
        check_value("inp_gnt_o", 32'(inp_gnt_o), 32'(expected));
        next_cycle();
    endtask

    // Empties every ID through the output port, then confirms each one is gone
    task automatic drain_all();
        for (int i = 0; i < id_queue_pkg::N_IDS; i++) begin
            while (model_q[i].size() > 0) begin
                access_entry(id_queue_pkg::id_t'(i), 1'b1);
            end
            access_entry(id_queue_pkg::id_t'(i), 1'b0);
        end
    endtask

    task automatic test_interleaved();
        for (int round = 0; round < 2; round++) begin
            push_entry(3'd1, rand_data());
            push_entry(3'd4, rand_data());
            push_entry(3'd6, rand_data());
        end
        // IDs are popped in a different order than they were pushed
        access_entry(3'd6, 1'b1);
        access_entry(3'd1, 1'b1);
        access_entry(3'd6, 1'b1);
        access_entry(3'd4, 1'b1);
        access_entry(3'd4, 1'b1);
        access_entry(3'd1, 1'b1);
        // Every ID must now report itself absent
        drain_all();
    endtask

    task automatic test_peek();
        push_entry(3'd2, rand_data());
        push_entry(3'd2, rand_data());
        access_entry(3'd2, 1'b0);
        access_entry(3'd2, 1'b0);
        access_entry(3'd2, 1'b1);
        access_entry(3'd2, 1'b0);
        access_entry(3'd2, 1'b1);
        access_entry(3'd2, 1'b0);
    endtask

    task automatic test_absent();
        push_entry(3'd0, rand_data());
        access_entry(3'd5, 1'b0);
        access_entry(3'd7, 1'b1);
        drain_all();
    endtask

    task automatic test_full();
        for (int i = 0; i < id_queue_pkg::CAPACITY; i++) begin
            push_entry(id_queue_pkg::id_t'(i % 3), rand_data());
        end
        // A held push on a full queue sees no grant and must store nothing
        inp_id_i   = 3'd2;
        inp_data_i = rand_data();
        inp_req_i  = 1'b1;
        check_push_grant(1'b0);
        check_push_grant(1'b0);
        inp_req_i = 1'b0;
        access_entry(3'd0, 1'b1);
        check_push_grant(1'b1);
        push_entry(3'd0, rand_data());
        drain_all();
    endtask

    task automatic test_priority();
        id_queue_pkg::data_t word;
        word       = rand_data();
        inp_id_i   = 3'd3;
        inp_data_i = word;
        inp_req_i  = 1'b1;
        oup_id_i   = 3'd3;
        oup_pop_i  = 1'b1;
        oup_req_i  = 1'b1;
        #4;
        check_value("inp_gnt_o", 32'(inp_gnt_o), 32'd1);
        check_value("oup_gnt_o", 32'(oup_gnt_o), 32'd0);
        check_value("oup_data_valid_o", 32'(oup_data_valid_o), 32'd0);
        model_q[3].push_back(word);
        next_cycle();
        inp_req_i = 1'b0;
        oup_req_i = 1'b0;
        oup_pop_i = 1'b0;
        while (model_count() < id_queue_pkg::CAPACITY) begin
            push_entry(3'd5, rand_data());
        end
        // With the queue full the waiting push loses the cycle to the pop
        inp_id_i   = 3'd5;
        inp_data_i = rand_data();
        inp_req_i  = 1'b1;
        access_entry(3'd3, 1'b1);
        inp_req_i = 1'b0;
        drain_all();
    endtask

    task automatic test_exists();
        probe_exists(16'hA5C3, 16'hFFFF, 1'b1);
        probe_exists(16'h0000, 16'h0000, 1'b1);
        push_entry(3'd0, 16'hA5C3);
        push_entry(3'd2, 16'h1234);
        push_entry(3'd2, rand_data());
        probe_exists(16'hA5C3, 16'hFFFF, 1'b1);
        probe_exists(16'h1234, 16'hFFFF, 1'b1);
        probe_exists(16'hA500, 16'hFF00, 1'b1);
        probe_exists(16'h5A3C, 16'hFFFF, 1'b1);
        probe_exists(16'hFFFF, 16'h0000, 1'b1);
        probe_exists(16'hA5C3, 16'hFFFF, 1'b0);
        access_entry(3'd0, 1'b1);
        probe_exists(16'hA5C3, 16'hFFFF, 1'b1);
        drain_all();
        probe_exists(16'h0000, 16'h0000, 1'b1);
    endtask

    initial begin
        seed          = 32'h89d;
        rst_ni        = 1'b0;
        inp_id_i      = '0;
        inp_data_i    = '0;
        inp_req_i     = 1'b0;
        oup_id_i      = '0;
        oup_pop_i     = 1'b0;
        oup_req_i     = 1'b0;
        exists_data_i = '0;
        exists_mask_i = '0;
        exists_req_i  = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        // After reset every entry is free and no output is active
        check_value("oup_gnt_o", 32'(oup_gnt_o), 32'd0);
        check_value("oup_data_valid_o", 32'(oup_data_valid_o), 32'd0);
        check_value("exists_o", 32'(exists_o), 32'd0);
        check_push_grant(1'b1);
        test_interleaved();
        test_peek();
        test_absent();
        test_full();
        test_priority();
        test_exists();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: filelist.f
logic/id_queue_pkg.sv
logic/id_queue_ctrl.sv
logic/id_head_tail_table.sv
logic/id_linked_data_store.sv
logic/id_exists_search.sv
logic/id_queue.sv
verif/tb_id_queue.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_id_queue
FILELIST  ?= filelist.f
PASS_MSG  := Test completed successfully

.PHONY: sim clean

# The run passes only if the pass message appears in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
